// ==== bench/cpu_pipelined_basic_asserts.sv ====
`timescale 1ns/1ps

module cpu_pipelined_basic_asserts (
   input logic                 clk,
   input logic                 rst,
   input logic [31:0]          pc_value,
   input cpu_pkg::store_port_t store,
   input logic                 stall,
   input logic                 squash_issue
);
   import cpu_pkg::*;

   int failures = 0;

   reset_state: assert property (@(posedge clk) !rst |-> !store.valid && pc_value == '0)
      else begin
         $error("store strobe or pc_value not cleared during reset");
         failures++;
      end

   store_known: assert property (@(posedge clk) disable iff (!rst) !$isunknown(store.valid))
      else begin
         $error("store strobe is unknown");
         failures++;
      end

   // A jump in decode resolves only when stall and squash never meet
   jump_resolves: assert property (@(posedge clk) disable iff (!rst)
      !(stall && squash_issue))
      else begin
         $error("stall raised while issue was being squashed for a jump");
         failures++;
      end

   pc_in_range: assert property (@(posedge clk) disable iff (!rst) pc_value < mem_depth)
      else begin
         $error("pc_value left the main memory range");
         failures++;
      end

endmodule

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;
   import cpu_pkg::*;

   localparam int reset_cycles    = 16;
   localparam int cycles_per_word = 40;
   localparam int max_steps       = 4096;
   localparam logic [mem_addr_bits-1:0] marker_addr = 8'hff;

   logic        clk = 1'b0;
   logic        rst;
   logic [31:0] pc_value;
   store_port_t store;

   logic [xlen-1:0]          model_mem [mem_depth];
   logic [xlen-1:0]          model_regs [reg_count];
   store_port_t              expected [$];
   logic [mem_addr_bits-1:0] final_pc;
   logic                     final_found;
   string test_names [6] = '{"reset", "load_imm_store", "alu_ops", "dependent_chain",
                             "store_load_store", "jumps"};
   int program_words  = 0;
   int timeout_cycles = 0;
   int seen           = 0;
   int errors         = 0;
   int test_errors    = 0;
   int tests_done     = 0;
   int tests_failed   = 0;

   cpu_pipelined_basic uut (
      .clk      (clk),
      .rst      (rst),
      .pc_value (pc_value),
      .store    (store)
   );

   bind cpu_pipelined_basic cpu_pipelined_basic_asserts checks (
      .clk          (clk),
      .rst          (rst),
      .pc_value     (pc_value),
      .store        (store),
      .stall        (stall),
      .squash_issue (squash_issue)
   );

   always #4 clk = ~clk;

   function automatic logic [xlen-1:0] alu_model(alu_op_e op, logic [xlen-1:0] a,
                                                 logic [xlen-1:0] b);
      case (op)
         alu_add: return a + b;
         alu_sub: return a - b;
         alu_and: return a & b;
         alu_or:  return a | b;
         alu_xor: return a ^ b;
         alu_shl: return a << b[4:0];
         default: return '0;
      endcase
   endfunction

   // Plain sequential run of the program, collecting every store in order
   task automatic build_expected();
      instr_u                   instr;
      logic [mem_addr_bits-1:0] pc;
      logic [mem_addr_bits-1:0] next_pc;
      logic [xlen-1:0]          a;
      logic [xlen-1:0]          b;
      store_port_t              st;
      pc = '0;
      final_found = 1'b0;
      foreach (model_regs[i]) begin
         model_regs[i] = '0;
      end
      for (int step = 0; step < max_steps && !final_found; step++) begin
         instr   = model_mem[pc];
         a       = model_regs[instr.reg_fmt.ra];
         b       = model_regs[instr.reg_fmt.rb];
         next_pc = pc + 8'd1;
         case (instr.reg_fmt.opcode)
            op_load_imm: model_regs[instr.imm_fmt.rd] = 32'($signed(instr.imm_fmt.imm));
            op_load_mem: model_regs[instr.reg_fmt.rd] = model_mem[a[mem_addr_bits-1:0]];
            op_alu:      model_regs[instr.reg_fmt.rd] = alu_model(instr.reg_fmt.alu_op, a, b);
            op_store: begin
               st.valid = 1'b1;
               st.addr  = b[mem_addr_bits-1:0];
               st.data  = a;
               expected.push_back(st);
               model_mem[st.addr] = a;
            end
            op_jump: begin
               if (a != '0) begin
                  next_pc     = b[mem_addr_bits-1:0];
                  final_found = next_pc == pc;
                  final_pc    = pc;
               end
            end
            default: ;
         endcase
         pc = next_pc;
      end
   endtask

   task automatic report_test();
      if (test_errors == 0) begin
         $display("test %0d %s: ok", tests_done, test_names[tests_done]);
      end else begin
         $display("test %0d %s: failed with %0d errors", tests_done, test_names[tests_done],
                  test_errors);
         tests_failed++;
      end
      tests_done++;
      test_errors = 0;
   endtask

   task automatic check_store();
      store_port_t exp;
      assert (seen < expected.size()) else begin
         $display("unexpected store of %h to address %h beyond the reference model's stores",
                  store.data, store.addr);
         errors++;
         test_errors++;
         return;
      end
      exp = expected[seen];
      seen++;
      assert (store.addr == exp.addr && store.data == exp.data) else begin
         $display("mismatch in %s: expected %h at %h, actual %h at %h", test_names[tests_done],
                  exp.data, exp.addr, store.data, store.addr);
         errors++;
         test_errors++;
      end
      if (exp.addr == marker_addr) begin
         report_test();
      end
   endtask

   // Strobe is combinational from the execute register, stable at the falling edge
   always @(negedge clk) begin
      if (rst && store.valid) begin
         check_store();
      end
   end

   initial begin
      wait (timeout_cycles > 0);
      repeat (timeout_cycles) @(posedge clk);
      $display("Timeout: program did not reach its final self-jump in %0d cycles",
               timeout_cycles);
      $display("Simulation finished: FAIL");
      $finish;
   end

   initial begin
      rst = 1'b0;
      // Fill words carry an unused opcode so the loaded program stands out
      foreach (model_mem[i]) begin
         model_mem[i] = 32'hdead0000 ^ 32'(i);
      end
      $readmemh("program.hex", model_mem);
      foreach (model_mem[i]) begin
         if (model_mem[i] !== (32'hdead0000 ^ 32'(i))) begin
            program_words++;
         end
      end
      timeout_cycles = reset_cycles + cycles_per_word * program_words;
      build_expected();
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      assert (pc_value == '0) else begin
         $display("mismatch in reset: expected pc_value %h, actual %h", 32'h0, pc_value);
         errors++;
         test_errors++;
      end
      assert (!store.valid) else begin
         $display("mismatch in reset: expected store.valid 0, actual %b", store.valid);
         errors++;
         test_errors++;
      end
      report_test();
      rst = 1'b1;
      assert (final_found) else begin
         $display("Reference model found no self-jump within %0d steps", max_steps);
         errors++;
      end
      while (final_found && !(seen == expected.size() && pc_value == {24'b0, final_pc})) begin
         @(negedge clk);
      end
      errors += uut.checks.failures;
      $display("%0d tests run, %0d failed, %0d errors in total", tests_done, tests_failed,
               errors);
      if (errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// ==== cpu_pipelined_basic.f ====
hw/cpu_pkg.sv
hw/register_file.sv
hw/instruction_decoder.sv
hw/hazard_control.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/cpu_pipelined_basic.sv
bench/cpu_pipelined_basic_asserts.sv
bench/cpu_tb.sv

// ==== hw/cpu_pipelined_basic.sv ====
`timescale 1ns/1ps

module cpu_pipelined_basic (
   input  logic                 clk,
   input  logic                 rst,
   output logic [31:0]          pc_value,
   output cpu_pkg::store_port_t store
);
   import cpu_pkg::*;

   logic [xlen-1:0] pc;
   logic [xlen-1:0] pc_next;
   logic            pc_en;
   logic            stall;
   logic            squash_issue;

   instr_u          fetch_instr;
   instr_u          issue_instr;

   logic [4:0]      read_reg_a;
   logic [4:0]      read_reg_b;
   logic [xlen-1:0] read_data_a;
   logic [xlen-1:0] read_data_b;
   logic [xlen-1:0] imm_value;

   pipe_stage_t     decode_next;
   pipe_stage_t     decode_stage;
   pipe_stage_t     execute_stage_out;
   pipe_stage_t     wb_stage;

   logic [4:0]      write_reg;
   logic [xlen-1:0] write_data;
   logic            write_en;

   assign pc_value = pc;

   hazard_control hazard (
      .issue_instr    (issue_instr),
      .decode_instr   (decode_stage.instr),
      .execute_instr  (execute_stage_out.instr),
      .wb_instr       (wb_stage.instr),
      .jump_condition (decode_stage.operand_a),
      .jump_target    (decode_stage.operand_b),
      .pc             (pc),
      .stall          (stall),
      .squash_issue   (squash_issue),
      .pc_en          (pc_en),
      .pc_next        (pc_next)
   );

   // Fetch stage state
   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         pc <= '0;
      end else if (pc_en) begin
         pc <= pc_next;
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         issue_instr <= '0;
      end else if (!stall) begin
         issue_instr <= squash_issue ? instr_u'('0) : fetch_instr;
      end
   end

   instruction_decoder decoder (
      .instr      (issue_instr),
      .read_reg_a (read_reg_a),
      .read_reg_b (read_reg_b),
      .imm_value  (imm_value)
   );

   register_file reg_file (
      .clk         (clk),
      .rst         (rst),
      .read_reg_a  (read_reg_a),
      .read_reg_b  (read_reg_b),
      .read_data_a (read_data_a),
      .read_data_b (read_data_b),
      .write_reg   (write_reg),
      .write_data  (write_data),
      .write_en    (write_en)
   );

   // A stalled issue sends a bubble down the pipe
   always_comb begin
      decode_next = '0;
      if (!stall) begin
         decode_next.instr     = issue_instr;
         decode_next.operand_a = read_data_a;
         decode_next.operand_b = (issue_instr.imm_fmt.opcode == op_load_imm) ?
                                 imm_value : read_data_b;
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         decode_stage <= '0;
      end else begin
         decode_stage <= decode_next;
      end
   end

   execute_stage execute (
      .clk               (clk),
      .rst               (rst),
      .decode_stage      (decode_stage),
      .execute_stage_out (execute_stage_out)
   );

   memory_stage memory (
      .clk               (clk),
      .rst               (rst),
      .pc                (pc),
      .fetch_instr       (fetch_instr),
      .execute_stage_out (execute_stage_out),
      .store             (store),
      .wb_stage          (wb_stage)
   );

   // Write back
   assign write_en   = writes_reg(wb_stage.instr);
   assign write_reg  = dest_reg(wb_stage.instr);
   assign write_data = wb_stage.result;

endmodule

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

   localparam int xlen          = 32;
   localparam int reg_count     = 32;
   localparam int mem_depth     = 256;
   localparam int mem_addr_bits = 8;

   // Top five bits of every instruction word
   typedef enum logic [4:0] {
      op_nop      = 5'd0,
      op_load_imm = 5'd1,
      op_load_mem = 5'd2,
      op_store    = 5'd3,
      op_alu      = 5'd4,
      op_jump     = 5'd5
   } opcode_e;

   typedef enum logic [4:0] {
      alu_add = 5'd0,
      alu_sub = 5'd1,
      alu_and = 5'd2,
      alu_or  = 5'd3,
      alu_xor = 5'd4,
      alu_shl = 5'd5
   } alu_op_e;

   typedef struct packed {
      opcode_e     opcode;
      logic [4:0]  rd;
      logic [21:0] imm;
   } imm_fmt_t;

   typedef struct packed {
      opcode_e    opcode;
      logic [4:0] ra;
      logic [4:0] rb;
      logic [4:0] rd;
      logic [6:0] unused;
      alu_op_e    alu_op;
   } reg_fmt_t;

   typedef union packed {
      imm_fmt_t imm_fmt;
      reg_fmt_t reg_fmt;
   } instr_u;

   typedef struct packed {
      instr_u          instr;
      logic [xlen-1:0] operand_a;
      logic [xlen-1:0] operand_b;
      logic [xlen-1:0] result;
   } pipe_stage_t;

   typedef struct packed {
      logic                     valid;
      logic [mem_addr_bits-1:0] addr;
      logic [xlen-1:0]          data;
   } store_port_t;

   function automatic logic writes_reg(instr_u instr);
      return instr.reg_fmt.opcode inside {op_load_imm, op_load_mem, op_alu};
   endfunction

   // Load immediate keeps its destination where the other formats hold ra
   function automatic logic [4:0] dest_reg(instr_u instr);
      return (instr.imm_fmt.opcode == op_load_imm) ? instr.imm_fmt.rd : instr.reg_fmt.rd;
   endfunction

   function automatic logic reads_reg_a(instr_u instr);
      return instr.reg_fmt.opcode inside {op_load_mem, op_store, op_alu, op_jump};
   endfunction

   function automatic logic reads_reg_b(instr_u instr);
      return instr.reg_fmt.opcode inside {op_store, op_alu, op_jump};
   endfunction

endpackage

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
   input  logic                 clk,
   input  logic                 rst,
   input  cpu_pkg::pipe_stage_t decode_stage,
   output cpu_pkg::pipe_stage_t execute_stage_out
);
   import cpu_pkg::*;

   logic [xlen-1:0] alu_result;
   pipe_stage_t     execute_next;

   always_comb begin
      case (decode_stage.instr.reg_fmt.alu_op)
         alu_add: alu_result = decode_stage.operand_a + decode_stage.operand_b;
         alu_sub: alu_result = decode_stage.operand_a - decode_stage.operand_b;
         alu_and: alu_result = decode_stage.operand_a & decode_stage.operand_b;
         alu_or:  alu_result = decode_stage.operand_a | decode_stage.operand_b;
         alu_xor: alu_result = decode_stage.operand_a ^ decode_stage.operand_b;
         alu_shl: alu_result = decode_stage.operand_a << decode_stage.operand_b[4:0];
         default: alu_result = '0;
      endcase
   end

   // Operands travel on so the memory stage has address and data
   always_comb begin
      execute_next = decode_stage;
      case (decode_stage.instr.reg_fmt.opcode)
         op_load_imm: execute_next.result = decode_stage.operand_b;
         op_alu:      execute_next.result = alu_result;
         default:     execute_next.result = '0;
      endcase
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         execute_stage_out <= '0;
      end else begin
         execute_stage_out <= execute_next;
      end
   end

endmodule

// ==== hw/hazard_control.sv ====
`timescale 1ns/1ps

module hazard_control (
   input  cpu_pkg::instr_u issue_instr,
   input  cpu_pkg::instr_u decode_instr,
   input  cpu_pkg::instr_u execute_instr,
   input  cpu_pkg::instr_u wb_instr,
   input  logic [31:0]     jump_condition,
   input  logic [31:0]     jump_target,
   input  logic [31:0]     pc,
   output logic            stall,
   output logic            squash_issue,
   output logic            pc_en,
   output logic [31:0]     pc_next
);
   import cpu_pkg::*;

   logic            hit_decode;
   logic            hit_execute;
   logic            hit_wb;
   logic            issue_is_jump;
   logic            decode_is_jump;
   logic            jump_taken;
   logic [xlen-1:0] pc_increment;

   // True when consumer reads a register that producer will write
   function automatic logic depends_on(instr_u consumer, instr_u producer);
      logic hit_a;
      logic hit_b;
      hit_a = reads_reg_a(consumer) && (consumer.reg_fmt.ra == dest_reg(producer));
      hit_b = reads_reg_b(consumer) && (consumer.reg_fmt.rb == dest_reg(producer));
      return writes_reg(producer) && (hit_a || hit_b);
   endfunction

   assign hit_decode  = depends_on(issue_instr, decode_instr);
   assign hit_execute = depends_on(issue_instr, execute_instr);
   assign hit_wb      = depends_on(issue_instr, wb_instr);
   assign stall       = hit_decode || hit_execute || hit_wb;

   assign issue_is_jump  = issue_instr.reg_fmt.opcode == op_jump;
   assign decode_is_jump = decode_instr.reg_fmt.opcode == op_jump;
   assign jump_taken     = decode_is_jump && (jump_condition != '0);

   // Issue is flushed while a jump is entering or sitting in decode
   assign squash_issue = (issue_is_jump && !stall) || decode_is_jump;

   assign pc_increment = pc + 32'd1;

   always_comb begin
      pc_en   = 1'b0;
      pc_next = pc_increment;
      if (decode_is_jump) begin
         pc_en   = jump_taken;
         pc_next = {{(xlen-mem_addr_bits){1'b0}}, jump_target[mem_addr_bits-1:0]};
      end else if (!stall && !issue_is_jump) begin
         pc_en = 1'b1;
      end
   end

endmodule

// ==== hw/instruction_decoder.sv ====
`timescale 1ns/1ps

module instruction_decoder (
   input  cpu_pkg::instr_u instr,
   output logic [4:0]      read_reg_a,
   output logic [4:0]      read_reg_b,
   output logic [31:0]     imm_value
);
   import cpu_pkg::*;

   localparam int imm_bits = $bits(instr.imm_fmt.imm);

   // Unused read ports point at r0
   always_comb begin
      read_reg_a = '0;
      read_reg_b = '0;
      if (reads_reg_a(instr)) begin
         read_reg_a = instr.reg_fmt.ra;
      end
      if (reads_reg_b(instr)) begin
         read_reg_b = instr.reg_fmt.rb;
      end
   end

   assign imm_value = {{(xlen-imm_bits){instr.imm_fmt.imm[imm_bits-1]}}, instr.imm_fmt.imm};

endmodule

// ==== hw/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [31:0]          pc,
   output cpu_pkg::instr_u      fetch_instr,
   input  cpu_pkg::pipe_stage_t execute_stage_out,
   output cpu_pkg::store_port_t store,
   output cpu_pkg::pipe_stage_t wb_stage
);
   import cpu_pkg::*;

   logic [xlen-1:0]          mem [mem_depth];
   logic [mem_addr_bits-1:0] load_addr;
   logic [xlen-1:0]          load_data;
   pipe_stage_t              wb_next;

   initial begin
      $readmemh("program.hex", mem);
   end

   // Port 0 fetches, port 1 serves loads
   assign fetch_instr = mem[pc[mem_addr_bits-1:0]];
   assign load_addr   = execute_stage_out.operand_a[mem_addr_bits-1:0];
   assign load_data   = mem[load_addr];

   // Store takes data from ra and address from rb
   assign store.valid = execute_stage_out.instr.reg_fmt.opcode == op_store;
   assign store.addr  = execute_stage_out.operand_b[mem_addr_bits-1:0];
   assign store.data  = execute_stage_out.operand_a;

   always_ff @(posedge clk) begin
      if (store.valid) begin
         mem[store.addr] <= store.data;
      end
   end

   always_comb begin
      wb_next = execute_stage_out;
      if (execute_stage_out.instr.reg_fmt.opcode == op_load_mem) begin
         wb_next.result = load_data;
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         wb_stage <= '0;
      end else begin
         wb_stage <= wb_next;
      end
   end

endmodule

// ==== hw/register_file.sv ====
`timescale 1ns/1ps

module register_file (
   input  logic        clk,
   input  logic        rst,
   input  logic [4:0]  read_reg_a,
   input  logic [4:0]  read_reg_b,
   output logic [31:0] read_data_a,
   output logic [31:0] read_data_b,
   input  logic [4:0]  write_reg,
   input  logic [31:0] write_data,
   input  logic        write_en
);
   import cpu_pkg::*;

   logic [xlen-1:0] regs [reg_count];

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         for (int i = 0; i < reg_count; i++) begin
            regs[i] <= '0;
         end
      end else if (write_en) begin
         regs[write_reg] <= write_data;
      end
   end

   // Same-cycle write is visible to the reader
   assign read_data_a = (write_en && (write_reg == read_reg_a)) ? write_data : regs[read_reg_a];
   assign read_data_b = (write_en && (write_reg == read_reg_b)) ? write_data : regs[read_reg_b];

endmodule

// ==== program.hex ====
// One 32-bit instruction word per entry from address 0, opcode in bits 31:27
// Words on one line belong together, data lives at 0x80 and up, 0xff is the test marker
08400123 08bffffb 08c00080 09000081
0fc000ff 0f800001 18460000 18880000 1fbe0000
// ALU on loaded words
0b400082 10c05000 11006000
214c7000 214c8001 214c9002 214ca003 214cb004 214cc005
19da0000 1a1a0000 1a5a0000 1a9a0000 1ada0000 1b1a0000
0f800002 1fbe0000
// Dependent chain
214ae000 238ce000 238ae004 2384e001 1b9a0000 0f800003 1fbe0000
// Store, load back, store again
0bd5a5a5 0c000084 1be00000 14011000 1c600000 0f800004 1fbe0000
// Not-taken jump, taken jump over two stores, self-jump at 0x31
0cc0002e 28260000 195a0000 28660000 199a0000 19da0000
0f800005 1fbe0000 0d000031 28680000

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Verilator build and run of the pipelined CPU testbench
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module cpu_tb \
   -f cpu_pipelined_basic.f \
   --Mdir "$build_dir" -o cpu_tb_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$build_dir/cpu_tb_sim" +verilator+error+limit+100 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Simulation finished: PASS" "$log_file"; then
   exit 0
fi
echo "Pass message not found in $log_file"
exit 1
